/* verification/mac_tx_golden.dat */
// Header ff0000ggggiiiioooo: flags (bit 0 starts the next frame early), min gap, user, out.
// User words mmdddddddddddddddd (mask, data); out words ccdddddddddddddddd (ctrl, txd).
// Frame 0: "12345678", aligned end.
000000000400020004
FF3837363534333231
000000000000000000
01D5555555555555FB
003837363534333231
F0070707FD9AE0DAAF
FF0707070707070707
// Frame 1: "1234567890", tail of two bytes, next start given mid frame.
010000000400020004
FF3837363534333231
030000000000003039
01D5555555555555FB
003837363534333231
C007FD261DAEE53039
FF0707070707070707
// Frame 2: "123456789", mask 01, corrupted CRC.
000000000400020004
FF3837363534333231
010000000000000039
01D5555555555555FB
003837363534333231
F0070707FDCBF43927
FF0707070707070707
// Frame 3: quick brown fox, mask 07, corrupted CRC.
000000000500060008
FF6369757120656854
FF206E776F7262206B
FF706D756A20786F66
FF74207265766F2073
FF20797A616C206568
070000000000676F64
01D5555555555555FB
006369757120656854
00206E776F7262206B
00706D756A20786F66
0074207265766F2073
0020797A616C206568
F0070707FD414FA338
FF0707070707070707
// Frame 4: "12345678" again after a longer gap.
000000000600020004
FF3837363534333231
000000000000000000
01D5555555555555FB
003837363534333231
F0070707FD9AE0DAAF
FF0707070707070707
// End of frames.
000000000000000000

/* vlog.f */
+incdir+include
verilog/mac_tx_pkg.sv
verilog/frame_sequencer.sv
verilog/lane_encoder.sv
verilog/crc32_engine.sv
verilog/crc_inserter.sv
verilog/mac_tx.sv
verification/mac_tx_chk.sv
verification/mac_tx_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = mac_tx_tb
FILELIST = vlog.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "Test passed" $(LOG); then echo "Simulation did not finish"; exit 1; fi
	@echo "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verification/mac_tx_tb.sv */
`timescale 1ns/100ps
`default_nettype none
`include "xgmii_macros.svh"

module mac_tx_tb;

  typedef struct packed {
    logic [31:0] due;   // Cycle the word shows on the outputs.
    logic [7:0]  frame;
    logic        last;
    logic [7:0]  ctrl;
    logic [63:0] word;
  } expect_t;

  logic        tx_clk;
  logic        reset;
  logic        tx_start;
  logic [63:0] tx_data;
  logic [7:0]  tx_data_valid;
  wire         tx_ack;
  wire  [63:0] xgmii_txd;
  wire  [7:0]  xgmii_txc;

  logic [71:0] golden [0:255];
  expect_t     exp_q[$];
  logic [31:0] cyc;
  logic [31:0] lfsr;
  int          error_count;
  int          frame_errs [0:63];
  int          tests_run;
  int          tests_failed;
  int          budget;
  bit          checking;

  mac_tx u_dut (
    .tx_clk        (tx_clk),
    .reset         (reset),
    .tx_start      (tx_start),
    .tx_data       (tx_data),
    .tx_data_valid (tx_data_valid),
    .tx_ack        (tx_ack),
    .xgmii_txd     (xgmii_txd),
    .xgmii_txc     (xgmii_txc)
  );

  initial begin
    tx_clk = 1'b0;
    forever #4 tx_clk = ~tx_clk;
  end

  always @(posedge tx_clk) begin
    if (reset) begin
      cyc <= 32'd0;
    end else begin
      cyc <= cyc + 32'd1; // Rising edges since reset.
    end
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  task automatic take_bits(input int n, output int value);
    value = 0;
    for (int i = 0; i < n; i++) begin
      value = (value << 1) | int'(lfsr[0]);
      lfsr  = lfsr_step(lfsr); // One step per bit.
    end
  endtask

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp, output bit ok);
    ok = (got === exp);
    if (!ok) begin
      error_count++;
      $display("[FAIL] %0t ns: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic report_lane(input logic [63:0] got, input logic [63:0] exp);
    mac_tx_pkg::xgmii_word_u g;
    mac_tx_pkg::xgmii_word_u x;
    g = got;
    x = exp;
    for (int i = 0; i < 8; i++) begin
      if (g.lane[i] !== x.lane[i]) begin
        $display("  first bad lane %0d: got %h, expected %h", i, g.lane[i], x.lane[i]);
        break;
      end
    end
  endtask

  task automatic finish_frame(input int idx);
    tests_run++;
    if (frame_errs[idx] != 0) begin
      tests_failed++;
    end
    $display("frame %0d done, %0d mismatching cycles", idx, frame_errs[idx]);
  endtask

  task automatic wait_ack(output int ack_cyc, output bit got);
    got = 1'b0;
    ack_cyc = 0;
    for (int n = 0; n < 64 && !got; n++) begin
      @(negedge tx_clk);
      if (tx_ack) begin
        got = 1'b1;
        ack_cyc = int'(cyc);
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Output monitor
  ////////////////////////////////////////////////////////////
  always @(negedge tx_clk) begin : out_monitor
    expect_t e;
    bit      ok_d;
    bit      ok_c;
    if (checking) begin
      if (exp_q.size() != 0 && exp_q[0].due == cyc) begin
        e = exp_q.pop_front();
        check_value("xgmii_txd", xgmii_txd, e.word, ok_d);
        check_value("xgmii_txc", {56'd0, xgmii_txc}, {56'd0, e.ctrl}, ok_c);
        if (!ok_d) begin
          report_lane(xgmii_txd, e.word);
        end
        if (!(ok_d && ok_c)) begin
          frame_errs[int'(e.frame)]++;
        end
        if (e.last) begin
          finish_frame(int'(e.frame));
        end
      end else begin
        check_value("idle xgmii_txd", xgmii_txd, `XGMII_IDLE_WORD, ok_d);
        check_value("idle xgmii_txc", {56'd0, xgmii_txc}, {56'd0, `CTRL_IDLE}, ok_c);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////
  initial begin : driver
    int          p;
    int          fidx;
    int          n_in;
    int          n_out;
    int          gap;
    int          extra;
    int          start_cyc;
    int          ack_cyc;
    int          end_cyc;
    int          total;
    int          idle_errs;
    bit          pending;
    bit          got;
    bit          ok;
    bit          abort;
    logic [71:0] hdr;
    expect_t     e;

    tx_start      = 1'b0;
    tx_data       = 64'd0;
    tx_data_valid = 8'd0;
    reset         = 1'b1;
    checking      = 1'b0;
    lfsr          = 32'h675b_c3d1;
    $readmemh("verification/mac_tx_golden.dat", golden);

    // Frame and gap cycles of the whole run.
    total = 0;
    p = 0;
    while (golden[p][31:16] != 16'd0) begin
      total = total + int'(golden[p][31:16]) + int'(golden[p][15:0]);
      total = total + int'(golden[p][47:32]) + 12; // Room for random gap and latency.
      p = p + 1 + int'(golden[p][31:16]) + int'(golden[p][15:0]);
    end
    budget = total * 2 + 200;

    repeat (10) @(posedge tx_clk);
    @(negedge tx_clk);
    reset    = 1'b0;
    checking = 1'b1;

    // No tx_ack and idle outputs while no start is given.
    idle_errs = error_count;
    repeat (8) begin
      @(negedge tx_clk);
      check_value("tx_ack while idle", {63'd0, tx_ack}, 64'd0, ok);
    end
    tests_run++;
    if (error_count != idle_errs) begin
      tests_failed++;
    end
    $display("idle after reset done, %0d errors", error_count - idle_errs);

    p       = 0;
    fidx    = 0;
    pending = 1'b0;
    abort   = 1'b0;
    end_cyc = 0;
    while (!abort && golden[p][31:16] != 16'd0) begin
      hdr   = golden[p];
      n_in  = int'(hdr[31:16]);
      n_out = int'(hdr[15:0]);
      start_cyc = 0;
      if (!pending) begin
        take_bits(3, extra);
        gap = int'(hdr[47:32]) + extra;
        repeat (gap) @(negedge tx_clk);
        tx_start  = 1'b1;
        start_cyc = int'(cyc);
        @(negedge tx_clk);
        tx_start = 1'b0;
      end
      wait_ack(ack_cyc, got);
      if (!got) begin
        $display("No tx_ack for frame %0d within 64 cycles, stopping", fidx);
        error_count++;
        tests_run++;
        tests_failed++;
        abort = 1'b1;
      end else begin
        // Latched starts wait for idle after the interframe word.
        if (pending) begin
          check_value("tx_ack cycle", 64'(ack_cyc), 64'(end_cyc + 4), ok);
        end else begin
          check_value("tx_ack cycle", 64'(ack_cyc), 64'(start_cyc + 2), ok);
        end
        if (!ok) begin
          frame_errs[fidx]++;
        end
        for (int j = 0; j < n_out; j++) begin
          e.due   = ack_cyc + 3 + j;
          e.frame = 8'(fidx);
          e.last  = (j == n_out - 1);
          e.ctrl  = golden[p + 1 + n_in + j][71:64];
          e.word  = golden[p + 1 + n_in + j][63:0];
          exp_q.push_back(e);
        end
        for (int j = 0; j < n_in; j++) begin
          if (j != 0) begin
            @(negedge tx_clk);
          end
          {tx_data_valid, tx_data} = golden[p + 1 + j];
          tx_start = hdr[64] && (j == 0); // Next start lands mid frame.
          end_cyc  = int'(cyc);
        end
        @(negedge tx_clk);
        tx_start      = 1'b0;
        tx_data       = 64'd0;
        tx_data_valid = 8'd0;
        pending       = hdr[64];
        p    = p + 1 + n_in + n_out;
        fidx = fidx + 1;
      end
    end

    while (exp_q.size() != 0) @(negedge tx_clk);
    repeat (4) @(negedge tx_clk);
    $display("%0d tests, %0d failed, %0d mismatches, %0d assertion failures",
             tests_run, tests_failed, error_count, u_dut.u_chk.fail_count);
    if (error_count == 0 && tests_failed == 0 && u_dut.u_chk.fail_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin : watchdog
    wait (budget != 0);
    repeat (budget) @(posedge tx_clk);
    $display("Watchdog expired after %0d cycles, the run did not finish", budget);
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

/* verification/mac_tx_chk.sv */
`timescale 1ns/100ps
`default_nettype none
`include "xgmii_macros.svh"

module mac_tx_chk (
  input wire       tx_clk,
  input wire       reset,
  input wire       tx_ack,
  input wire [7:0] xgmii_txc
);

  int fail_count = 0; // Assertion failures so far.

  ////////////////////////////////////////////////////////////
  // Protocol properties
  ////////////////////////////////////////////////////////////
  a_ack_single : assert property (@(posedge tx_clk) disable iff (reset)
    tx_ack |=> !tx_ack)
    else begin
      $error("tx_ack high for two cycles");
      fail_count++;
    end

  // Pipe needs three edges before the control settles.
  a_reset_idle : assert property (@(posedge tx_clk)
    reset && $past(reset, 1) && $past(reset, 2) && $past(reset, 3)
      |-> xgmii_txc == `CTRL_IDLE)
    else begin
      $error("xgmii_txc not idle during reset");
      fail_count++;
    end

  a_start_data : assert property (@(posedge tx_clk) disable iff (reset)
    xgmii_txc == `CTRL_PREAMBLE |=> xgmii_txc == `CTRL_DATA)
    else begin
      $error("start word not followed by data control");
      fail_count++;
    end

endmodule

bind mac_tx mac_tx_chk u_chk (
  .tx_clk    (tx_clk),
  .reset     (reset),
  .tx_ack    (tx_ack),
  .xgmii_txc (xgmii_txc)
);

`default_nettype wire

/* verilog/mac_tx.sv */
`timescale 1ns/100ps
`default_nettype none

module mac_tx (
  input  wire        tx_clk,
  input  wire        reset,
  input  wire        tx_start,
  input  wire [63:0] tx_data,
  input  wire [7:0]  tx_data_valid,
  output wire        tx_ack,
  output wire [63:0] xgmii_txd,
  output wire [7:0]  xgmii_txc
);

  wire mac_tx_pkg::tx_stage_t stage;
  wire mac_tx_pkg::encoded_t  encoded;
  wire                        crc_restart;
  wire [31:0]                 crc;

  ////////////////////////////////////////////////////////////
  // Transmit pipe
  ////////////////////////////////////////////////////////////
  frame_sequencer u_sequencer (
    .tx_clk        (tx_clk),
    .reset         (reset),
    .tx_start      (tx_start),
    .tx_data       (tx_data),
    .tx_data_valid (tx_data_valid),
    .tx_ack        (tx_ack),
    .stage         (stage),
    .crc_restart   (crc_restart)
  );

  lane_encoder u_encoder (
    .tx_clk  (tx_clk),
    .stage   (stage),
    .encoded (encoded)
  );

  // Runs on the raw user words, two cycles ahead of the encoder.
  crc32_engine u_crc (
    .tx_clk      (tx_clk),
    .crc_restart (crc_restart),
    .data        (tx_data),
    .data_valid  (tx_data_valid),
    .crc         (crc)
  );

  crc_inserter u_inserter (
    .tx_clk    (tx_clk),
    .encoded   (encoded),
    .crc       (crc),
    .xgmii_txd (xgmii_txd),
    .xgmii_txc (xgmii_txc)
  );

endmodule

`default_nettype wire

/* verilog/crc_inserter.sv */
`timescale 1ns/100ps
`default_nettype none

module crc_inserter (
  input  wire                  tx_clk,
  input  wire mac_tx_pkg::encoded_t encoded,
  input  wire  [31:0]          crc,
  output logic [63:0]          xgmii_txd,
  output logic [7:0]           xgmii_txc
);

  mac_tx_pkg::encoded_t    held;    // Waits for the CRC to finish.
  mac_tx_pkg::xgmii_word_u spliced;

  always_ff @(posedge tx_clk) begin
    held <= encoded;
  end

  ////////////////////////////////////////////////////////////
  // CRC splice
  ////////////////////////////////////////////////////////////
  always_comb begin
    spliced = held.word;
    case (held.state)
      mac_tx_pkg::send_end_aligned: begin
        spliced.half.lower = crc;
      end
      mac_tx_pkg::send_corrupted_crc: begin
        spliced.half.lower = {crc[31:1], ~crc[0]}; // Receiver will see a bad FCS.
      end
      mac_tx_pkg::send_end_tail2: begin
        spliced.lane[5:2] = crc; // Shifted past the two tail bytes.
      end
      default: begin
        spliced = held.word;
      end
    endcase
  end

  assign xgmii_txd = spliced;
  assign xgmii_txc = held.ctrl;

endmodule

`default_nettype wire

/* verilog/crc32_engine.sv */
`timescale 1ns/100ps
`default_nettype none
`include "xgmii_macros.svh"

module crc32_engine (
  input  wire         tx_clk,
  input  wire         crc_restart,
  input  wire  [63:0] data,
  input  wire  [7:0]  data_valid,
  output logic [31:0] crc
);

  logic [63:0] data_q;
  logic [7:0]  valid_q;
  logic        restart_q;
  logic [31:0] crc_q;    // Running remainder, not yet inverted.
  logic [31:0] crc_next;

  // One byte through the reflected CRC-32, LSB first.
  function automatic logic [31:0] crc_byte(input logic [31:0] crc_in,
                                           input logic [7:0]  data_byte);
    logic [31:0] c;
    c = crc_in ^ {24'h00_0000, data_byte};
    for (int b = 0; b < 8; b++) begin
      if (c[0]) begin
        c = (c >> 1) ^ `CRC32_POLY;
      end else begin
        c = c >> 1;
      end
    end
    return c;
  endfunction

  ////////////////////////////////////////////////////////////
  // Input register
  ////////////////////////////////////////////////////////////
  always_ff @(posedge tx_clk) begin
    data_q    <= data;
    valid_q   <= data_valid;
    restart_q <= crc_restart; // Lines up with the first data word.
  end

  ////////////////////////////////////////////////////////////
  // 64-bit update, lane 0 first
  ////////////////////////////////////////////////////////////
  always_comb begin
    crc_next = restart_q ? `CRC32_INIT : crc_q;
    for (int i = 0; i < 8; i++) begin
      if (valid_q[i]) begin
        crc_next = crc_byte(crc_next, data_q[8*i +: 8]); // Skip masked lanes.
      end
    end
  end

  always_ff @(posedge tx_clk) begin
    crc_q <= crc_next;
  end

  assign crc = ~crc_q; // Final inversion, byte 0 in bits 7:0.

endmodule

`default_nettype wire

/* verilog/lane_encoder.sv */
`timescale 1ns/100ps
`default_nettype none
`include "xgmii_macros.svh"

module lane_encoder (
  input  wire                   tx_clk,
  input  wire mac_tx_pkg::tx_stage_t stage,
  output mac_tx_pkg::encoded_t  encoded
);

  mac_tx_pkg::xgmii_word_u word_next;
  logic [7:0]              ctrl_next;

  ////////////////////////////////////////////////////////////
  // State to XGMII word and lane control
  ////////////////////////////////////////////////////////////
  always_comb begin
    word_next = stage.word; // Data lanes pass through unless replaced.
    ctrl_next = `CTRL_IDLE;
    case (stage.state)
      mac_tx_pkg::send_preamble: begin
        word_next = `XGMII_PREAMBLE_WORD;
        ctrl_next = `CTRL_PREAMBLE;
      end
      mac_tx_pkg::send_data: begin
        ctrl_next = `CTRL_DATA;
      end
      mac_tx_pkg::send_end_aligned,
      mac_tx_pkg::send_corrupted_crc: begin
        word_next.lane[3:0] = '0;                  // CRC goes here later.
        word_next.lane[4]   = `XGMII_TERM;
        word_next.lane[7:5] = {3{`XGMII_IDLE}};
        ctrl_next           = `CTRL_END_ALIGNED;
      end
      mac_tx_pkg::send_end_tail2: begin
        // Lanes 0 and 1 keep the tail bytes.
        word_next.lane[5:2] = '0;                  // Room for the CRC.
        word_next.lane[6]   = `XGMII_TERM;
        word_next.lane[7]   = `XGMII_IDLE;
        ctrl_next           = `CTRL_END_TAIL2;
      end
      default: begin
        word_next = `XGMII_IDLE_WORD; // Idle, interframe and unused codes.
        ctrl_next = `CTRL_IDLE;
      end
    endcase
  end

  always_ff @(posedge tx_clk) begin
    encoded.state <= stage.state;
    encoded.word  <= word_next;
    encoded.ctrl  <= ctrl_next;
  end

endmodule

`default_nettype wire

/* verilog/frame_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none

module frame_sequencer (
  input  wire                    tx_clk,
  input  wire                    reset,
  input  wire                    tx_start,
  input  wire  [63:0]            tx_data,
  input  wire  [7:0]             tx_data_valid,
  output logic                   tx_ack,
  output mac_tx_pkg::tx_stage_t  stage,
  output logic                   crc_restart
);

  mac_tx_pkg::tx_state_e state;      // Follows the word sampled at the same edge.
  mac_tx_pkg::tx_state_e mask_state; // Where the current mask leads.
  logic                  start_pending;
  logic [63:0]           tx_data_z;

  ////////////////////////////////////////////////////////////
  // Mask decode
  ////////////////////////////////////////////////////////////
  // A full mask keeps the frame going, anything else ends it.
  always_comb begin
    case (tx_data_valid)
      8'b1111_1111: mask_state = mac_tx_pkg::send_data;
      8'b0000_0000: mask_state = mac_tx_pkg::send_end_aligned;
      8'b0000_0011: mask_state = mac_tx_pkg::send_end_tail2;    // Two tail bytes.
      default:      mask_state = mac_tx_pkg::send_corrupted_crc; // Unsupported tail.
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Frame FSM
  ////////////////////////////////////////////////////////////
  always_ff @(posedge tx_clk) begin
    if (reset) begin
      state         <= mac_tx_pkg::idle;
      start_pending <= 1'b0;
      tx_ack        <= 1'b0;
    end else begin
      tx_ack <= 1'b0; // Single-cycle strobe.

      if (tx_start) begin
        start_pending <= 1'b1; // Held until the path is idle.
      end

      case (state)
        mac_tx_pkg::idle: begin
          if (start_pending) begin
            tx_ack        <= 1'b1;
            start_pending <= 1'b0;
            state         <= mac_tx_pkg::send_preamble;
          end
        end
        mac_tx_pkg::send_preamble,
        mac_tx_pkg::send_data: begin
          state <= mask_state; // First word is sampled while in preamble.
        end
        mac_tx_pkg::send_end_aligned,
        mac_tx_pkg::send_end_tail2,
        mac_tx_pkg::send_corrupted_crc: begin
          state <= mac_tx_pkg::interframe;
        end
        mac_tx_pkg::interframe: begin
          state <= mac_tx_pkg::idle;
        end
        default: begin
          state <= mac_tx_pkg::idle;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Stage register
  ////////////////////////////////////////////////////////////
  always_ff @(posedge tx_clk) begin
    tx_data_z  <= tx_data;   // Pairs the word with its state.
    stage.word <= tx_data_z;
    if (reset) begin
      stage.state <= mac_tx_pkg::idle;
    end else begin
      stage.state <= state;
    end
  end

  // The CRC engine seeds its first data word from this.
  assign crc_restart = (state == mac_tx_pkg::send_preamble);

endmodule

`default_nettype wire

/* verilog/mac_tx_pkg.sv */
`default_nettype none

package mac_tx_pkg;

  // Frame state, shared by every stage of the transmit pipe.
  typedef enum logic [2:0] {
    idle               = 3'd0,
    send_preamble      = 3'd1,
    send_data          = 3'd2,
    send_end_aligned   = 3'd3,
    send_end_tail2     = 3'd4,
    send_corrupted_crc = 3'd5,
    interframe         = 3'd6
  } tx_state_e;

  // Sequencer output, state with the user word it goes with.
  typedef struct packed {
    tx_state_e   state;
    logic [63:0] word;
  } tx_stage_t;

  // One XGMII word, seen as lanes or as two 32-bit halves.
  typedef union packed {
    logic [7:0][7:0] lane; // Lane 0 is the first byte on the wire.
    struct packed {
      logic [31:0] upper;
      logic [31:0] lower; // Lanes 0 to 3.
    } half;
  } xgmii_word_u;

  // Encoder output, before the CRC is spliced in.
  typedef struct packed {
    tx_state_e   state;
    xgmii_word_u word;
    logic [7:0]  ctrl;
  } encoded_t;

endpackage

`default_nettype wire

/* include/xgmii_macros.svh */
`ifndef XGMII_MACROS_SVH
`define XGMII_MACROS_SVH

////////////////////////////////////////////////////////////
// XGMII character codes
////////////////////////////////////////////////////////////
`define XGMII_IDLE_WORD     64'h0707_0707_0707_0707 // Idle in all eight lanes.
`define XGMII_PREAMBLE_WORD 64'hd555_5555_5555_55fb // Start in lane 0, SFD in lane 7.
`define XGMII_TERM          8'hfd                   // Terminate character.
`define XGMII_IDLE          8'h07                   // Idle character.

////////////////////////////////////////////////////////////
// Lane control patterns, bit n set means lane n is control
////////////////////////////////////////////////////////////
`define CTRL_IDLE           8'b1111_1111
`define CTRL_PREAMBLE       8'b0000_0001 // Only the start lane.
`define CTRL_DATA           8'b0000_0000
`define CTRL_END_ALIGNED    8'b1111_0000 // Terminate in lane 4.
`define CTRL_END_TAIL2      8'b1100_0000 // Terminate in lane 6.

////////////////////////////////////////////////////////////
// Ethernet CRC-32
////////////////////////////////////////////////////////////
`define CRC32_POLY          32'hedb8_8320 // Reflected form of 04C11DB7.
`define CRC32_INIT          32'hffff_ffff

`endif
